//--- rtl/cnn_core_pkg.sv
// sizes, widths and the five-layer schedule of the CNN core controller
// imported by every RTL module and by the testbench
`default_nettype none

package cnn_core_pkg;

    // array geometry defaults, overridden through module parameters
    localparam int PE_COL       = 2;
    localparam int PE_ROW       = 2;
    localparam int FM_BUF_DEPTH = 64;

    // one buffer word carries nine activation bytes
    localparam int FM_WORD_W      = 72;
    localparam int ACT_W          = 8;
    localparam int BYTES_PER_WORD = 9;

    localparam int DIM_W      = 8;
    localparam int LAYER_W    = 3;
    localparam int NUM_LAYERS = 5;

    // end_of_row while the width count is 1 .. END_ROW_MARGIN-1
    localparam int END_ROW_MARGIN = 6;

    // per-layer sizes, indexed by layer number
    localparam logic [DIM_W-1:0] LAYER_W_NUM [1:NUM_LAYERS] =
        '{8'd200, 8'd98, 8'd47, 8'd22, 8'd20};
    localparam logic [DIM_W-1:0] LAYER_H_NUM [1:NUM_LAYERS] =
        '{8'd66, 8'd31, 8'd14, 8'd5, 8'd3};
    localparam logic [DIM_W-1:0] LAYER_C_NUM [1:NUM_LAYERS] =
        '{8'd3, 8'd24, 8'd36, 8'd48, 8'd64};

    // 3x3 kernels in the first three layers
    localparam logic LAYER_KERNEL_MODE [1:NUM_LAYERS] =
        '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0};

endpackage

`default_nettype wire

//--- rtl/fm_buffer.sv
// one column's feature-map memory, one write port and a registered read
`timescale 1ns/1ps
`default_nettype none

module fm_buffer #(
    parameter int  FM_BUF_DEPTH = cnn_core_pkg::FM_BUF_DEPTH,
    localparam int ADDR_W       = $clog2(FM_BUF_DEPTH)
) (
    input  wire                                 clk,
    input  wire                                 wr_en,
    input  wire  [ADDR_W-1:0]                   wr_addr,
    input  wire  [cnn_core_pkg::FM_WORD_W-1:0]  wr_data,
    input  wire  [ADDR_W-1:0]                   rd_addr,
    output logic [cnn_core_pkg::FM_WORD_W-1:0]  rd_data
);
    import cnn_core_pkg::*;

    logic [FM_WORD_W-1:0] mem [FM_BUF_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        // read data valid one cycle after rd_addr
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

//--- rtl/fm_wr_arbiter.sv
// write port select for one column buffer
// the host load port owns it while idle, PE write-back while running
`timescale 1ns/1ps
`default_nettype none

module fm_wr_arbiter #(
    parameter int  FM_BUF_DEPTH = cnn_core_pkg::FM_BUF_DEPTH,
    localparam int ADDR_W       = $clog2(FM_BUF_DEPTH)
) (
    input  wire                                 core_ready,
    input  wire                                 load_wr_en,
    input  wire  [ADDR_W-1:0]                   load_wr_addr,
    input  wire  [cnn_core_pkg::FM_WORD_W-1:0]  load_din,
    input  wire                                 wb_wr_en,
    input  wire  [ADDR_W-1:0]                   wb_wr_addr,
    input  wire  [cnn_core_pkg::ACT_W-1:0]      wb_din,
    output logic                                wr_en,
    output logic [ADDR_W-1:0]                   wr_addr,
    output logic [cnn_core_pkg::FM_WORD_W-1:0]  wr_data
);
    import cnn_core_pkg::*;

    always_comb begin
        if (core_ready) begin
            wr_en   = load_wr_en;
            wr_addr = load_wr_addr;
            wr_data = load_din;
        end else begin
            // write-back byte lands in the low byte of the word
            wr_en   = wb_wr_en;
            wr_addr = wb_wr_addr;
            wr_data = {{(FM_WORD_W - ACT_W){1'b0}}, wb_din};
        end
    end

endmodule

`default_nettype wire

//--- rtl/act_fetch.sv
// per-column activation fetch, one byte per activation_en, MSB first
// tracks the pixel position of the layer and prefetches the next buffer word
`timescale 1ns/1ps
`default_nettype none

module act_fetch #(
    parameter int  FM_BUF_DEPTH = cnn_core_pkg::FM_BUF_DEPTH,
    localparam int ADDR_W       = $clog2(FM_BUF_DEPTH)
) (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire                                 start_layer,
    input  wire                                 in_process,
    input  wire                                 activation_en,
    input  wire  [cnn_core_pkg::DIM_W-1:0]      w_num,
    input  wire  [cnn_core_pkg::DIM_W-1:0]      h_num,
    input  wire  [cnn_core_pkg::FM_WORD_W-1:0]  rd_data,
    output logic [ADDR_W-1:0]                   rd_addr,
    output logic [cnn_core_pkg::ACT_W-1:0]      activation,
    output logic                                is_odd_row,
    output logic                                end_of_row
);
    import cnn_core_pkg::*;

    localparam int BCNT_W = $clog2(BYTES_PER_WORD);

    logic [DIM_W-1:0]     count_w;
    logic [DIM_W-1:0]     count_h;
    logic [BCNT_W-1:0]    byte_cnt;
    logic [FM_WORD_W-1:0] shift_fm;
    logic                 step;
    logic                 row_end;
    logic                 plane_end;
    logic                 word_end;
    logic                 restart;
    logic                 fill_d1;
    logic                 fill_d2;

    assign step      = in_process && activation_en;
    assign row_end   = step && (count_w == DIM_W'(1));
    assign plane_end = row_end && (count_h == DIM_W'(1));
    assign word_end  = step && (byte_cnt == BCNT_W'(BYTES_PER_WORD - 1));
    // fetch starts over from word 0 at layer start and at each plane wrap
    assign restart   = start_layer || plane_end;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_w    <= '0;
            count_h    <= '0;
            is_odd_row <= 1'b1;
        end else if (start_layer) begin
            count_w    <= w_num;
            count_h    <= h_num;
            is_odd_row <= 1'b1;
        end else if (row_end) begin
            count_w    <= w_num;
            is_odd_row <= ~is_odd_row;
            if (plane_end) begin
                count_h <= h_num;
            end else begin
                count_h <= count_h - 1'b1;
            end
        end else if (step) begin
            count_w <= count_w - 1'b1;
        end
    end

    // fill_d2 marks the cycle word 0 is back from the buffer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_addr  <= '0;
            byte_cnt <= '0;
            fill_d1  <= 1'b0;
            fill_d2  <= 1'b0;
        end else begin
            fill_d1 <= restart;
            fill_d2 <= fill_d1;
            if (restart) begin
                rd_addr  <= '0;
                byte_cnt <= '0;
            end else if (fill_d2 || word_end) begin
                // word taken, prefetch the following one
                rd_addr  <= rd_addr + 1'b1;
                byte_cnt <= '0;
            end else if (step) begin
                byte_cnt <= byte_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_d2 || word_end) begin
            shift_fm <= rd_data;
        end else if (step) begin
            shift_fm <= {shift_fm[FM_WORD_W-ACT_W-1:0], {ACT_W{1'b0}}};
        end
    end

    assign activation = shift_fm[FM_WORD_W-1 -: ACT_W];
    assign end_of_row = (count_w != '0) && (count_w < DIM_W'(END_ROW_MARGIN));

endmodule

`default_nettype wire

//--- rtl/wb_router.sv
// routes PE-row write-back bytes to the column buffers
// row-to-column mapping is rotated at each layer start and row finish
`timescale 1ns/1ps
`default_nettype none

module wb_router #(
    parameter int  PE_COL       = cnn_core_pkg::PE_COL,
    parameter int  PE_ROW       = cnn_core_pkg::PE_ROW,
    parameter int  FM_BUF_DEPTH = cnn_core_pkg::FM_BUF_DEPTH,
    localparam int ADDR_W       = $clog2(FM_BUF_DEPTH)
) (
    input  wire                                         clk,
    input  wire                                         rst_n,
    input  wire                                         start_layer,
    input  wire  [PE_ROW-1:0]                           write_back_finish,
    input  wire  [PE_ROW-1:0]                           wb_valid,
    input  wire  [PE_ROW-1:0][cnn_core_pkg::ACT_W-1:0]  wb_data,
    output logic [PE_COL-1:0]                           wb_wr_en,
    output logic [PE_COL-1:0][ADDR_W-1:0]               wb_wr_addr,
    output logic [PE_COL-1:0][cnn_core_pkg::ACT_W-1:0]  wb_din
);
    // wide enough for ports that rotate past the last column
    localparam int PORT_W = 8;

    logic [PORT_W-1:0] wb_port [PE_ROW];
    logic [ADDR_W-1:0] wb_addr [PE_ROW];

    for (genvar r = 0; r < PE_ROW; r++) begin : g_row
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                wb_port[r] <= PORT_W'(PE_ROW - 1 - r);
                wb_addr[r] <= '0;
            end else if (start_layer) begin
                wb_port[r] <= PORT_W'(PE_ROW - 1 - r);
                wb_addr[r] <= '0;
            end else if (write_back_finish[r]) begin
                wb_port[r] <= wb_port[r] + PORT_W'(PE_ROW);
                wb_addr[r] <= '0;
            end else if (wb_valid[r]) begin
                wb_addr[r] <= wb_addr[r] + 1'b1;
            end
        end
    end

    always_comb begin
        wb_wr_en   = '0;
        wb_wr_addr = '0;
        wb_din     = '0;
        for (int c = 0; c < PE_COL; c++) begin
            for (int r = 0; r < PE_ROW; r++) begin
                if (wb_port[r] == PORT_W'(c)) begin
                    wb_wr_en[c]   = wb_valid[r];
                    wb_wr_addr[c] = wb_addr[r];
                    wb_din[c]     = wb_data[r];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/layer_sequencer.sv
// host start/finish protocol and five-layer schedule of the CNN core
// in difference mode each layer runs twice, bit_mode low then high
`timescale 1ns/1ps
`default_nettype none

module layer_sequencer #(
    parameter int PE_ROW = cnn_core_pkg::PE_ROW
) (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire                             core_valid,
    input  wire                             core_is_diff,
    input  wire  [PE_ROW-1:0]               write_back_finish,
    output logic                            core_ready,
    output logic                            core_finish,
    output logic                            is_diff,
    output logic                            bit_mode,
    output logic                            start_layer,
    output logic                            in_process,
    output logic                            layer_done,
    output logic [cnn_core_pkg::DIM_W-1:0]  w_num,
    output logic [cnn_core_pkg::DIM_W-1:0]  h_num,
    output logic [cnn_core_pkg::DIM_W-1:0]  c_num,
    output logic                            kernel_mode,
    output logic                            is_first
);
    import cnn_core_pkg::*;

    localparam logic [2:0] S_IDLE             = 3'd0;
    localparam logic [2:0] S_START            = 3'd1;
    localparam logic [2:0] S_PROCESS          = 3'd2;
    localparam logic [2:0] S_FINISH_ONE_LAYER = 3'd3;
    localparam logic [2:0] S_FINISH           = 3'd4;

    logic [2:0]         state;
    logic [2:0]         next_state;
    logic [LAYER_W-1:0] layer_num;
    logic               pass;
    logic [PE_ROW-1:0]  wb_seen;
    logic               accept;
    logic               last_pass;

    assign accept     = core_valid && core_ready;
    assign layer_done = &wb_seen;
    assign last_pass  = pass && (layer_num == LAYER_W'(NUM_LAYERS));
    assign in_process = (state == S_PROCESS);
    // pass is held at 1 outside difference mode
    assign bit_mode   = is_diff && pass;

    always_comb begin
        next_state = state;
        case (state)
            S_IDLE: begin
                if (accept) begin
                    next_state = S_START;
                end
            end
            S_START: next_state = S_PROCESS;
            S_PROCESS: begin
                if (layer_done) begin
                    next_state = last_pass ? S_FINISH : S_FINISH_ONE_LAYER;
                end
            end
            S_FINISH_ONE_LAYER: next_state = S_START;
            S_FINISH: next_state = S_IDLE;
            default: next_state = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= S_IDLE;
            core_ready  <= 1'b1;
            core_finish <= 1'b0;
            is_diff     <= 1'b0;
            start_layer <= 1'b0;
            wb_seen     <= '0;
        end else begin
            state       <= next_state;
            core_finish <= (state == S_FINISH);
            // high exactly while the FSM sits in START
            start_layer <= (next_state == S_START);
            if (accept) begin
                core_ready <= 1'b0;
                is_diff    <= core_is_diff;
            end else if (core_finish) begin
                core_ready <= 1'b1;
            end
            // a finish arriving with layer_done counts for the next layer
            if (layer_done) begin
                wb_seen <= write_back_finish;
            end else begin
                wb_seen <= wb_seen | write_back_finish;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            layer_num <= '0;
            pass      <= 1'b1;
        end else if (accept) begin
            layer_num <= LAYER_W'(1);
            pass      <= !core_is_diff;
        end else if (state == S_IDLE) begin
            layer_num <= '0;
        end else if (in_process && layer_done) begin
            if (pass && !last_pass) begin
                layer_num <= layer_num + 1'b1;
            end
            if (is_diff) begin
                pass <= ~pass;
            end
        end
    end

    // size lookup, zero outside a run
    always_comb begin
        w_num       = '0;
        h_num       = '0;
        c_num       = '0;
        kernel_mode = 1'b0;
        is_first    = (layer_num == LAYER_W'(1));
        if (layer_num >= LAYER_W'(1) && layer_num <= LAYER_W'(NUM_LAYERS)) begin
            w_num       = LAYER_W_NUM[layer_num];
            h_num       = LAYER_H_NUM[layer_num];
            c_num       = LAYER_C_NUM[layer_num];
            kernel_mode = LAYER_KERNEL_MODE[layer_num];
        end
    end

endmodule

`default_nettype wire

//--- rtl/cnn_core_top.sv
// CNN core controller top level with per-column fetch, arbitration and buffers
// the host loads the buffers while idle, then starts the five-layer run
`timescale 1ns/1ps
`default_nettype none

module cnn_core_top #(
    parameter int  PE_COL       = cnn_core_pkg::PE_COL,
    parameter int  PE_ROW       = cnn_core_pkg::PE_ROW,
    parameter int  FM_BUF_DEPTH = cnn_core_pkg::FM_BUF_DEPTH,
    localparam int ADDR_W       = $clog2(FM_BUF_DEPTH)
) (
    input  wire                                              clk,
    input  wire                                              rst_n,
    input  wire                                              core_valid,
    input  wire                                              core_is_diff,
    input  wire  [PE_COL-1:0]                                activation_en,
    input  wire  [PE_ROW-1:0]                                write_back_finish,
    input  wire  [PE_ROW-1:0]                                wb_valid,
    input  wire  [PE_ROW-1:0][cnn_core_pkg::ACT_W-1:0]       wb_data,
    input  wire  [PE_COL-1:0]                                load_wr_en,
    input  wire  [PE_COL-1:0][ADDR_W-1:0]                    load_wr_addr,
    input  wire  [PE_COL-1:0][cnn_core_pkg::FM_WORD_W-1:0]   load_din,
    output wire                                              core_ready,
    output wire                                              core_finish,
    output wire                                              is_diff,
    output wire                                              bit_mode,
    output wire                                              kernel_mode,
    output wire                                              is_first,
    output wire  [cnn_core_pkg::DIM_W-1:0]                   w_num,
    output wire  [cnn_core_pkg::DIM_W-1:0]                   h_num,
    output wire  [cnn_core_pkg::DIM_W-1:0]                   c_num,
    output wire  [PE_COL-1:0][cnn_core_pkg::ACT_W-1:0]       activation,
    output wire  [PE_COL-1:0]                                is_odd_row,
    output wire  [PE_COL-1:0]                                end_of_row
);
    import cnn_core_pkg::*;

    wire                              start_layer;
    wire                              in_process;
    wire [PE_COL-1:0]                 wb_wr_en;
    wire [PE_COL-1:0][ADDR_W-1:0]     wb_wr_addr;
    wire [PE_COL-1:0][ACT_W-1:0]      wb_din;
    wire [PE_COL-1:0]                 fm_wr_en;
    wire [PE_COL-1:0][ADDR_W-1:0]     fm_wr_addr;
    wire [PE_COL-1:0][FM_WORD_W-1:0]  fm_wr_data;
    wire [PE_COL-1:0][ADDR_W-1:0]     fm_rd_addr;
    wire [PE_COL-1:0][FM_WORD_W-1:0]  fm_rd_data;

    layer_sequencer #(
        .PE_ROW (PE_ROW)
    ) u_layer_sequencer (
        .clk               (clk),
        .rst_n             (rst_n),
        .core_valid        (core_valid),
        .core_is_diff      (core_is_diff),
        .write_back_finish (write_back_finish),
        .core_ready        (core_ready),
        .core_finish       (core_finish),
        .is_diff           (is_diff),
        .bit_mode          (bit_mode),
        .start_layer       (start_layer),
        .in_process        (in_process),
        .layer_done        (),
        .w_num             (w_num),
        .h_num             (h_num),
        .c_num             (c_num),
        .kernel_mode       (kernel_mode),
        .is_first          (is_first)
    );

    wb_router #(
        .PE_COL       (PE_COL),
        .PE_ROW       (PE_ROW),
        .FM_BUF_DEPTH (FM_BUF_DEPTH)
    ) u_wb_router (
        .clk               (clk),
        .rst_n             (rst_n),
        .start_layer       (start_layer),
        .write_back_finish (write_back_finish),
        .wb_valid          (wb_valid),
        .wb_data           (wb_data),
        .wb_wr_en          (wb_wr_en),
        .wb_wr_addr        (wb_wr_addr),
        .wb_din            (wb_din)
    );

    for (genvar c = 0; c < PE_COL; c++) begin : g_col
        act_fetch #(
            .FM_BUF_DEPTH (FM_BUF_DEPTH)
        ) u_act_fetch (
            .clk           (clk),
            .rst_n         (rst_n),
            .start_layer   (start_layer),
            .in_process    (in_process),
            .activation_en (activation_en[c]),
            .w_num         (w_num),
            .h_num         (h_num),
            .rd_data       (fm_rd_data[c]),
            .rd_addr       (fm_rd_addr[c]),
            .activation    (activation[c]),
            .is_odd_row    (is_odd_row[c]),
            .end_of_row    (end_of_row[c])
        );

        fm_wr_arbiter #(
            .FM_BUF_DEPTH (FM_BUF_DEPTH)
        ) u_fm_wr_arbiter (
            .core_ready   (core_ready),
            .load_wr_en   (load_wr_en[c]),
            .load_wr_addr (load_wr_addr[c]),
            .load_din     (load_din[c]),
            .wb_wr_en     (wb_wr_en[c]),
            .wb_wr_addr   (wb_wr_addr[c]),
            .wb_din       (wb_din[c]),
            .wr_en        (fm_wr_en[c]),
            .wr_addr      (fm_wr_addr[c]),
            .wr_data      (fm_wr_data[c])
        );

        fm_buffer #(
            .FM_BUF_DEPTH (FM_BUF_DEPTH)
        ) u_fm_buffer (
            .clk     (clk),
            .wr_en   (fm_wr_en[c]),
            .wr_addr (fm_wr_addr[c]),
            .wr_data (fm_wr_data[c]),
            .rd_addr (fm_rd_addr[c]),
            .rd_data (fm_rd_data[c])
        );
    end

endmodule

`default_nettype wire

//--- include/cnn_core_tb_tasks.svh
// compare tasks and random source of the CNN core testbench
// included in the testbench module body, uses test_name, test_errs, lfsr_state
`ifndef CNN_CORE_TB_TASKS_SVH
`define CNN_CORE_TB_TASKS_SVH

task automatic check_byte(input string what, input logic [ACT_W-1:0] exp,
                          input logic [ACT_W-1:0] act);
    if (act !== exp) begin
        $display("ERR %s %s: expected %h, got %h", test_name, what, exp, act);
        test_errs++;
    end
endtask

task automatic check_dim(input string what, input logic [DIM_W-1:0] exp,
                         input logic [DIM_W-1:0] act);
    if (act !== exp) begin
        $display("ERR %s %s: expected %0d, got %0d", test_name, what, exp, act);
        test_errs++;
    end
endtask

task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
        $display("ERR %s %s: expected %b, got %b", test_name, what, exp, act);
        test_errs++;
    end
endtask

// 16-bit Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// one LFSR step per bit, first bit ends up most significant
task automatic take_bits(input int n, output logic [FM_WORD_W-1:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        bits       = {bits[FM_WORD_W-2:0], lfsr_state[0]};
    end
endtask

`endif

//--- tb/tb_cnn_core.sv
// testbench for the CNN core controller top level
// loads the column buffers, runs the layer schedule and checks every pass
`timescale 1ns/1ps
`default_nettype none

module tb_cnn_core;
    import cnn_core_pkg::*;

    localparam int ADDR_W     = $clog2(FM_BUF_DEPTH);
    localparam int NUM_TESTS  = 4;
    localparam int WAIT_LIMIT = 200;

    // name, difference mode, words loaded per column, write-back bytes per row,
    // expected number of layer passes before core_finish
    string t_name   [NUM_TESTS] = '{"normal_full", "diff_full", "normal_short", "diff_wb_long"};
    logic  t_diff   [NUM_TESTS] = '{1'b0, 1'b1, 1'b0, 1'b1};
    int    t_load   [NUM_TESTS] = '{23, 23, 5, 14};
    int    t_wb     [NUM_TESTS] = '{6, 4, 9, 12};
    int    t_rounds [NUM_TESTS] = '{5, 10, 5, 10};

    logic                             clk;
    logic                             rst_n;
    logic                             core_valid;
    logic                             core_is_diff;
    logic [PE_COL-1:0]                activation_en;
    logic [PE_ROW-1:0]                write_back_finish;
    logic [PE_ROW-1:0]                wb_valid;
    logic [PE_ROW-1:0][ACT_W-1:0]     wb_data;
    logic [PE_COL-1:0]                load_wr_en;
    logic [PE_COL-1:0][ADDR_W-1:0]    load_wr_addr;
    logic [PE_COL-1:0][FM_WORD_W-1:0] load_din;
    wire                              core_ready;
    wire                              core_finish;
    wire                              is_diff;
    wire                              bit_mode;
    wire                              kernel_mode;
    wire                              is_first;
    wire  [DIM_W-1:0]                 w_num;
    wire  [DIM_W-1:0]                 h_num;
    wire  [DIM_W-1:0]                 c_num;
    wire  [PE_COL-1:0][ACT_W-1:0]     activation;
    wire  [PE_COL-1:0]                is_odd_row;
    wire  [PE_COL-1:0]                end_of_row;

    // scoreboard of the column buffers
    logic [FM_WORD_W-1:0] model    [PE_COL][FM_BUF_DEPTH];
    logic                 model_ok [PE_COL][FM_BUF_DEPTH];
    logic [15:0]          lfsr_state;
    logic                 timed_out;
    string                test_name;
    int                   test_errs;
    int                   total_errs;
    int                   failed_tests;
    int                   tests_run;

    `include "cnn_core_tb_tasks.svh"

    cnn_core_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic wait_ready_low();
        int t;
        t = 0;
        @(negedge clk);
        while (core_ready && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (core_ready) begin
            $display("start was never accepted, core_ready stayed high");
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_finish();
        int t;
        t = 0;
        @(negedge clk);
        while (!core_finish && t < WAIT_LIMIT) begin
            check_flag("core_ready before finish", 1'b0, core_ready);
            @(negedge clk);
            t++;
        end
        if (!core_finish) begin
            $display("no core_finish pulse after the last layer");
            timed_out = 1'b1;
        end
    endtask

    task automatic load_buffers(input int n_words);
        logic [FM_WORD_W-1:0] word;
        for (int a = 0; a < n_words; a++) begin
            @(posedge clk);
            load_wr_en <= '1;
            for (int c = 0; c < PE_COL; c++) begin
                take_bits(FM_WORD_W, word);
                load_wr_addr[c] <= ADDR_W'(a);
                load_din[c]     <= word;
                model[c][a]    = word;
                model_ok[c][a] = 1'b1;
            end
        end
        @(posedge clk);
        load_wr_en <= '0;
    endtask

    // one layer pass, entered at the falling edge inside the START cycle
    task automatic run_round(input int layer, input logic diff, input logic bmode,
                             input int n_wb);
        int                   w;
        int                   wi;
        logic [FM_WORD_W-1:0] word;
        logic [ACT_W-1:0]     exp_byte;
        w = int'(LAYER_W_NUM[layer]);
        check_dim("w_num", LAYER_W_NUM[layer], w_num);
        check_dim("h_num", LAYER_H_NUM[layer], h_num);
        check_dim("c_num", LAYER_C_NUM[layer], c_num);
        check_flag("kernel_mode", LAYER_KERNEL_MODE[layer], kernel_mode);
        check_flag("is_first", layer == 1, is_first);
        check_flag("is_diff", diff, is_diff);
        check_flag("bit_mode", bmode, bit_mode);
        check_flag("core_ready", 1'b0, core_ready);
        check_flag("core_finish", 1'b0, core_finish);
        // word 0 sits in the shift register three edges after START
        repeat (3) begin
            @(posedge clk);
            core_valid   <= 1'b0;
            // mode input is free to change once the start is taken
            core_is_diff <= ~diff;
        end
        activation_en <= '1;
        for (int k = 0; k < w; k++) begin
            @(negedge clk);
            wi = k / BYTES_PER_WORD;
            for (int c = 0; c < PE_COL; c++) begin
                word     = model[c][wi];
                exp_byte = word[FM_WORD_W - 1 - ACT_W * (k % BYTES_PER_WORD) -: ACT_W];
                if (model_ok[c][wi]) begin
                    check_byte($sformatf("activation[%0d] px %0d", c, k), exp_byte, activation[c]);
                end
                check_flag($sformatf("end_of_row[%0d] px %0d", c, k),
                           (w - k) < END_ROW_MARGIN, end_of_row[c]);
                check_flag($sformatf("is_odd_row[%0d] px %0d", c, k), 1'b1, is_odd_row[c]);
            end
            @(posedge clk);
        end
        activation_en <= '0;
        @(negedge clk);
        for (int c = 0; c < PE_COL; c++) begin
            check_flag($sformatf("is_odd_row[%0d] after row", c), 1'b0, is_odd_row[c]);
            check_flag($sformatf("end_of_row[%0d] after row", c), 1'b0, end_of_row[c]);
        end
        // row r lands in column PE_ROW-1-r, load writes meanwhile are dropped
        for (int j = 0; j < n_wb; j++) begin
            @(posedge clk);
            wb_valid   <= '1;
            load_wr_en <= '1;
            for (int r = 0; r < PE_ROW; r++) begin
                take_bits(ACT_W, word);
                wb_data[r] <= word[ACT_W-1:0];
                model[PE_ROW-1-r][j]    = {{(FM_WORD_W - ACT_W){1'b0}}, word[ACT_W-1:0]};
                model_ok[PE_ROW-1-r][j] = 1'b1;
            end
            for (int c = 0; c < PE_COL; c++) begin
                load_wr_addr[c] <= ADDR_W'(j);
                load_din[c]     <= {BYTES_PER_WORD{8'hc3}};
            end
        end
        @(posedge clk);
        wb_valid          <= '0;
        load_wr_en        <= '0;
        write_back_finish <= '1;
        @(posedge clk);
        write_back_finish <= '0;
    endtask

    initial begin
        rst_n             = 1'b0;
        core_valid        = 1'b0;
        core_is_diff      = 1'b0;
        activation_en     = '0;
        write_back_finish = '0;
        wb_valid          = '0;
        wb_data           = '0;
        load_wr_en        = '0;
        load_wr_addr      = '0;
        load_din          = '0;
        lfsr_state        = 16'd61235;
        timed_out         = 1'b0;
        total_errs        = 0;
        failed_tests      = 0;
        tests_run         = 0;
        for (int c = 0; c < PE_COL; c++) begin
            for (int a = 0; a < FM_BUF_DEPTH; a++) begin
                model[c][a]    = '0;
                model_ok[c][a] = 1'b0;
            end
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < NUM_TESTS && !timed_out; i++) begin
            test_name = t_name[i];
            test_errs = 0;
            tests_run++;
            @(negedge clk);
            check_flag("core_ready idle", 1'b1, core_ready);
            load_buffers(t_load[i]);
            @(posedge clk);
            core_is_diff <= t_diff[i];
            core_valid   <= 1'b1;
            wait_ready_low();
            if (!timed_out) begin
                for (int n = 0; n < t_rounds[i]; n++) begin
                    run_round(t_diff[i] ? n / 2 + 1 : n + 1, t_diff[i],
                              t_diff[i] && n % 2 == 1, n == 0 ? t_wb[i] : 0);
                    // FINISH_ONE_LAYER, then START of the next pass
                    if (n < t_rounds[i] - 1) begin
                        repeat (2) @(posedge clk);
                        @(negedge clk);
                    end
                end
                wait_finish();
            end
            if (!timed_out) begin
                @(negedge clk);
                check_flag("core_finish width", 1'b0, core_finish);
                check_flag("core_ready after finish", 1'b1, core_ready);
            end
            if (timed_out) begin
                failed_tests++;
                $display("test %s: timed out", test_name);
            end else if (test_errs == 0) begin
                $display("test %s: ok", test_name);
            end else begin
                failed_tests++;
                $display("test %s: %0d mismatches", test_name, test_errs);
            end
            total_errs += test_errs;
        end
        $display("%0d tests run, %0d failed, %0d mismatches", tests_run, failed_tests, total_errs);
        if (total_errs == 0 && !timed_out) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- cnn_core_ctrl.f
+incdir+include
rtl/cnn_core_pkg.sv
rtl/fm_buffer.sv
rtl/fm_wr_arbiter.sv
rtl/act_fetch.sv
rtl/wb_router.sv
rtl/layer_sequencer.sv
rtl/cnn_core_top.sv
tb/tb_cnn_core.sv
